//--- project.f
common/dcachePkg.sv
hw/lsuAlign.sv
dcache/dcacheArray.sv
dcache/dcacheCtrl.sv
hw/dcacheTop.sv
sim/memModel.sv
sim/dcacheCtrl_chk.sv
sim/dcacheTb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - common/dcachePkg.sv
  - hw/lsuAlign.sv
  - dcache/dcacheArray.sv
  - dcache/dcacheCtrl.sv
  - hw/dcacheTop.sv
  - target: test
    files:
      - sim/memModel.sv
      - sim/dcacheCtrl_chk.sv
      - sim/dcacheTb.sv

//--- sim/dcacheTb.sv
`default_nettype none

module dcacheTb
  import dcachePkg::*;
();

  localparam int NumLines   = 16;
  localparam int MemWords   = 1024;
  localparam int AccessWait = 200;
  localparam int FlushWait  = 3000;

  logic       clk = 1'b0;
  logic       reset;
  logic       memRead, memWrite, signedLoad, flush;
  accessSizeT accessSize;
  wordT       addr, storeData, loadData;
  logic       stall;
  logic       busReq, busWrite, busReady;
  wordT       busAddr, busWData, busRData;

  wordT        shadow [MemWords];
  logic        touched [MemWords];
  logic [31:0] rngState = 32'h3e0b_cdc2;
  int          checkCount = 0;
  int          errorCount = 0;
  int          testErrors = 0;
  int          testNum = 0;
  logic        timedOut = 1'b0;

  dcacheTop #(.numLines(NumLines)) i_dut (
    .clk(clk), .reset(reset),
    .memRead(memRead), .memWrite(memWrite), .accessSize(accessSize),
    .signedLoad(signedLoad), .flush(flush), .addr(addr), .storeData(storeData),
    .loadData(loadData), .stall(stall),
    .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr), .busWData(busWData),
    .busRData(busRData), .busReady(busReady)
  );

  memModel #(.memWords(MemWords), .seed(32'h3e0b_cdc2)) i_mem (
    .clk(clk), .reset(reset),
    .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr), .busWData(busWData),
    .busRData(busRData), .busReady(busReady)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic wordT nextRand();
    rngState = lcgNext(rngState);
    return rngState;
  endfunction

  // Expected load result from the shadow memory
  function automatic wordT refLoad(input wordT a, input accessSizeT size, input logic sgn);
    wordT        w;
    logic [7:0]  b;
    logic [15:0] h;
    w = shadow[a[11:2]];
    b = w[8*a[1:0] +: 8];
    h = a[1] ? w[31:16] : w[15:0];
    case (size)
      SizeByte: return sgn ? {{24{b[7]}}, b} : {24'b0, b};
      SizeHalf: return sgn ? {{16{h[15]}}, h} : {16'b0, h};
      default:  return w;
    endcase
  endfunction

  function automatic void applyStore(input wordT a, input accessSizeT size, input wordT d);
    int idx;
    idx = int'(a[11:2]);
    case (size)
      SizeByte: shadow[idx][8*a[1:0] +: 8] = d[7:0];
      SizeHalf: shadow[idx][16*a[1] +: 16] = d[15:0];
      default:  shadow[idx] = d;
    endcase
    touched[idx] = 1'b1;
  endfunction

  task automatic checkEq(input string what, input wordT got, input wordT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("Error at time %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Compare loads and track stores as they complete
  always @(posedge clk) begin
    if (!reset && !stall && memRead) begin
      checkEq($sformatf("load %h", addr), loadData, refLoad(addr, accessSize, signedLoad));
    end
    if (!reset && !stall && memWrite) begin
      applyStore(addr, accessSize, storeData);
    end
  end

  task automatic waitStallLow(input int limit, input string what, output logic sawStall);
    int waited;
    waited = 0;
    @(posedge clk);
    sawStall = stall;
    while (stall && !timedOut) begin
      if (waited == limit) begin
        timedOut = 1'b1;
        $display("Timeout: stall stayed high for %0d cycles during %s", limit, what);
      end else begin
        waited++;
        @(posedge clk);
      end
    end
  endtask

  // Starts and ends on a falling edge
  task automatic runAccess(input logic write, input accessSizeT size, input logic sgn,
                           input wordT a, input wordT data, output logic sawMiss);
    sawMiss = 1'b0;
    if (timedOut) begin
      return;
    end
    memRead    = ~write;
    memWrite   = write;
    accessSize = size;
    signedLoad = sgn;
    addr       = a;
    storeData  = data;
    waitStallLow(AccessWait, $sformatf("an access to %h", a), sawMiss);
    @(negedge clk);
    memRead  = 1'b0;
    memWrite = 1'b0;
  endtask

  task automatic flushCache();
    logic sawStall;
    if (timedOut) begin
      return;
    end
    flush = 1'b1;
    waitStallLow(FlushWait, "a flush", sawStall);
    @(negedge clk);
    flush = 1'b0;
  endtask

  task automatic compareMemory();
    if (timedOut) begin
      return;
    end
    for (int i = 0; i < MemWords; i++) begin
      if (touched[i]) begin
        checkEq($sformatf("memory word %0d", i), i_mem.mem[i], shadow[i]);
      end
    end
  endtask

  task automatic endTest(input string name);
    testNum++;
    $display("Test %0d %s: %0d errors", testNum, name, errorCount - testErrors);
    testErrors = errorCount;
  endtask

  initial begin
    logic       m;
    wordT       r;
    wordT       a;
    accessSizeT sz;
    int         assertFails;
    reset      = 1'b1;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    accessSize = SizeWord;
    signedLoad = 1'b0;
    flush      = 1'b0;
    addr       = '0;
    storeData  = '0;
    for (int i = 0; i < MemWords; i++) begin
      touched[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // Shadow starts from the memory preload
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = i_mem.mem[i];
    end

    runAccess(1'b0, SizeWord, 1'b0, 32'h040, '0, m);
    checkEq("cold load miss flag", 32'(m), 32'd1);
    runAccess(1'b0, SizeWord, 1'b0, 32'h048, '0, m);
    checkEq("same block hit flag", 32'(m), 32'd0);
    endTest("load miss then hit");

    for (int off = 0; off < 4; off++) begin
      runAccess(1'b1, SizeByte, 1'b0, 32'h080 + off, nextRand(), m);
    end
    runAccess(1'b1, SizeHalf, 1'b0, 32'h084, nextRand(), m);
    runAccess(1'b1, SizeHalf, 1'b0, 32'h086, nextRand(), m);
    runAccess(1'b1, SizeWord, 1'b0, 32'h088, nextRand(), m);
    for (int w = 0; w < 3; w++) begin
      for (int off = 0; off < 4; off++) begin
        for (int s = 0; s < 2; s++) begin
          a = 32'h080 + 4 * w + off;
          runAccess(1'b0, SizeByte, s[0], a, '0, m);
          if (off % 2 == 0) begin
            runAccess(1'b0, SizeHalf, s[0], a, '0, m);
          end
          if (off == 0) begin
            runAccess(1'b0, SizeWord, s[0], a, '0, m);
          end
        end
      end
    end
    endTest("byte and halfword access");

    // Two dirty blocks in set 6, then a third block pushes them out
    runAccess(1'b1, SizeWord, 1'b0, 32'h060, nextRand(), m);
    runAccess(1'b1, SizeWord, 1'b0, 32'h164, nextRand(), m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h268, '0, m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h060, '0, m);
    checkEq("evicted block refetch flag", 32'(m), 32'd1);
    runAccess(1'b0, SizeWord, 1'b0, 32'h164, '0, m);
    checkEq("evicted block refetch flag", 32'(m), 32'd1);
    endTest("dirty eviction");

    runAccess(1'b0, SizeWord, 1'b0, 32'h0a0, '0, m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h1a4, '0, m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h0a0, '0, m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h2a8, '0, m);
    runAccess(1'b0, SizeWord, 1'b0, 32'h0ac, '0, m);
    checkEq("recently used block hit flag", 32'(m), 32'd0);
    runAccess(1'b0, SizeWord, 1'b0, 32'h1a4, '0, m);
    checkEq("LRU block miss flag", 32'(m), 32'd1);
    endTest("LRU choice");

    runAccess(1'b1, SizeWord, 1'b0, 32'h0c0, nextRand(), m);
    runAccess(1'b1, SizeWord, 1'b0, 32'h1c4, nextRand(), m);
    runAccess(1'b1, SizeHalf, 1'b0, 32'h0da, nextRand(), m);
    runAccess(1'b1, SizeByte, 1'b0, 32'h2ed, nextRand(), m);
    runAccess(1'b1, SizeWord, 1'b0, 32'h1f0, nextRand(), m);
    flushCache();
    compareMemory();
    endTest("flush");

    // Four tags over four sets force evictions in a two-way cache
    for (int n = 0; n < 300; n++) begin
      r  = nextRand();
      sz = (r[25:24] == 2'd0) ? SizeByte : ((r[25:24] == 2'd1) ? SizeHalf : SizeWord);
      a  = 32'({r[31:30], 2'b00, r[29:28], r[27:26], 2'b00});
      if (sz == SizeByte) begin
        a[1:0] = r[23:22];
      end else if (sz == SizeHalf) begin
        a[1] = r[23];
      end
      runAccess(r[21], sz, r[20], a, nextRand(), m);
    end
    flushCache();
    compareMemory();
    endTest("random mix");

    assertFails = i_dut.i_dcacheCtrl.i_chk.failCount;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checkCount, errorCount, assertFails);
    if (timedOut || errorCount != 0 || assertFails != 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dcacheCtrl_chk.sv
`default_nettype none

module dcacheCtrl_chk
  import dcachePkg::*;
(
  input logic        clk,
  input logic        reset,
  input dcacheStateT state,
  input logic        memRead,
  input logic        memWrite,
  input logic        flush,
  input logic        stall,
  input logic        busReq,
  input logic        busWrite,
  input wordT        busAddr,
  input logic        busReady
);

  int failCount = 0;

  // A waiting beat keeps its request, address and direction
  busHold: assert property (@(posedge clk) disable iff (reset)
    busReq && !busReady |=> busReq && $stable(busAddr) && $stable(busWrite))
    else begin
      failCount++;
      $error("bus beat changed before busReady");
    end

  // The refilled line must hit when the access replays
  replayHit: assert property (@(posedge clk) disable iff (reset)
    state == NextAccess |=> !stall)
    else begin
      failCount++;
      $error("stall still high after the refill");
    end

  // Without a request or flush the controller stays off the bus
  idleBus: assert property (@(posedge clk) disable iff (reset)
    state == Ready && !memRead && !memWrite && !flush |=> !busReq)
    else begin
      failCount++;
      $error("busReq rose without a request");
    end

endmodule

bind dcacheCtrl dcacheCtrl_chk i_chk (
  .clk(clk), .reset(reset), .state(state),
  .memRead(memRead), .memWrite(memWrite), .flush(flush), .stall(stall),
  .busReq(busReq), .busWrite(busWrite), .busAddr(busAddr), .busReady(busReady)
);

`default_nettype wire

//--- sim/memModel.sv
`default_nettype none

module memModel
  import dcachePkg::*;
#(
  parameter int          memWords = 1024,
  parameter logic [31:0] seed     = 32'h3e0b_cdc2
) (
  input  logic clk,
  input  logic reset,
  input  logic busReq,
  input  logic busWrite,
  input  wordT busAddr,
  input  wordT busWData,
  output wordT busRData,
  output logic busReady
);

  localparam int idxBits = $clog2(memWords);

  wordT               mem [memWords];
  logic [31:0]        rngState;
  logic [1:0]         waitCount;
  logic [idxBits-1:0] wordIdx;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Preload with an LCG sequence mixed with the word address
  initial begin
    rngState = seed;
    for (int i = 0; i < memWords; i++) begin
      rngState = lcgNext(rngState);
      mem[i] = rngState ^ 32'(i);
    end
  end

  assign wordIdx = busAddr[idxBits-1:0];

  // Each beat waits 0 to 3 cycles, then busReady pulses once
  always @(posedge clk, posedge reset) begin
    if (reset) begin
      busReady  <= 1'b0;
      busRData  <= '0;
      waitCount <= '0;
    end else if (busReady) begin
      busReady  <= 1'b0;
      rngState  <= lcgNext(rngState);
      waitCount <= rngState[29:28];
    end else if (busReq) begin
      if (waitCount != 2'd0) begin
        waitCount <= waitCount - 1'b1;
      end else begin
        busReady <= 1'b1;
        if (busWrite) begin
          mem[wordIdx] <= busWData;
        end else begin
          busRData <= mem[wordIdx];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dcacheTop.sv
`default_nettype none

module dcacheTop
  import dcachePkg::*;
#(
  parameter int numLines = 16,
  localparam int idxBits = $clog2(numLines),
  localparam int tagBits = AddrBits - BlockOffBits - idxBits
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       memRead,
  input  logic       memWrite,
  input  accessSizeT accessSize,
  input  logic       signedLoad,
  input  logic       flush,
  input  wordT       addr,
  input  wordT       storeData,
  output wordT       loadData,
  output logic       stall,
  output logic       busReq,
  output logic       busWrite,
  output wordT       busAddr,
  output wordT       busWData,
  input  wordT       busRData,
  input  logic       busReady
);

  byteMaskT               byteMask;
  wordT                   laneData;
  wordT                   readWord;
  logic [idxBits-1:0]     setIndex;
  logic [WordOffBits-1:0] wordIndex;
  logic [1:0]             wayWE;
  logic                   fromBus;
  logic [tagBits-1:0]     writeTag;
  logic                   setDirty, clearDirty, setValid, touchLru;
  logic [tagBits-1:0]     wayTag0, wayTag1;
  logic [1:0]             wayValid, wayDirty;
  wordT                   wayWord0, wayWord1;
  logic                   lruWay;
  logic                   readWay;

  // Word of the hitting way goes to the load path
  assign readWord = readWay ? wayWord1 : wayWord0;

  lsuAlign i_lsuAlign (
    .accessSize (accessSize),
    .signedLoad (signedLoad),
    .byteOffset (addr[1:0]),
    .storeData  (storeData),
    .readWord   (readWord),
    .byteMask   (byteMask),
    .laneData   (laneData),
    .loadData   (loadData)
  );

  dcacheArray #(.numLines(numLines)) i_dcacheArray (
    .clk(clk), .reset(reset),
    .setIndex(setIndex), .wordIndex(wordIndex), .wayWE(wayWE),
    .fromBus(fromBus), .busRData(busRData), .laneData(laneData),
    .byteMask(byteMask), .writeTag(writeTag),
    .setDirty(setDirty), .clearDirty(clearDirty),
    .setValid(setValid), .touchLru(touchLru),
    .wayTag0(wayTag0), .wayTag1(wayTag1),
    .wayValid(wayValid), .wayDirty(wayDirty),
    .wayWord0(wayWord0), .wayWord1(wayWord1), .lruWay(lruWay)
  );

  dcacheCtrl #(.numLines(numLines)) i_dcacheCtrl (
    .clk(clk), .reset(reset),
    .memRead(memRead), .memWrite(memWrite), .flush(flush), .addr(addr),
    .wayTag0(wayTag0), .wayTag1(wayTag1),
    .wayValid(wayValid), .wayDirty(wayDirty),
    .wayWord0(wayWord0), .wayWord1(wayWord1), .lruWay(lruWay),
    .setIndex(setIndex), .wordIndex(wordIndex), .wayWE(wayWE),
    .fromBus(fromBus), .writeTag(writeTag),
    .setDirty(setDirty), .clearDirty(clearDirty),
    .setValid(setValid), .touchLru(touchLru), .readWay(readWay),
    .stall(stall),
    .busReq(busReq), .busWrite(busWrite),
    .busAddr(busAddr), .busWData(busWData), .busReady(busReady)
  );

endmodule

`default_nettype wire

//--- dcache/dcacheCtrl.sv
`default_nettype none

module dcacheCtrl
  import dcachePkg::*;
#(
  parameter int numLines = 16,
  localparam int idxBits = $clog2(numLines),
  localparam int tagBits = AddrBits - BlockOffBits - idxBits
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               memRead,
  input  logic               memWrite,
  input  logic               flush,
  input  wordT               addr,
  input  logic [tagBits-1:0] wayTag0,
  input  logic [tagBits-1:0] wayTag1,
  input  logic [1:0]         wayValid,
  input  logic [1:0]         wayDirty,
  input  wordT               wayWord0,
  input  wordT               wayWord1,
  input  logic               lruWay,
  output logic [idxBits-1:0] setIndex,
  output logic [WordOffBits-1:0] wordIndex,
  output logic [1:0]         wayWE,
  output logic               fromBus,
  output logic [tagBits-1:0] writeTag,
  output logic               setDirty,
  output logic               clearDirty,
  output logic               setValid,
  output logic               touchLru,
  output logic               readWay,
  output logic               stall,
  output logic               busReq,
  output logic               busWrite,
  output wordT               busAddr,
  output wordT               busWData,
  input  logic               busReady
);

  dcacheStateT state, nextState;

  logic [tagBits-1:0]     reqTag;
  logic [idxBits-1:0]     reqIdx;
  logic [WordOffBits-1:0] reqWord;
  logic [WordOffBits-1:0] beat;
  logic                   lastBeat;
  logic [idxBits:0]       flushCount;
  logic [idxBits-1:0]     flushSet;
  logic                   flushWay;
  logic                   flushLast;
  logic                   flushStep;
  logic                   flushDone;
  logic                   flushPending;
  logic                   cpuAccess;
  logic                   hit0, hit1, hit;
  logic                   victimWay;
  logic                   victimDirty;
  logic                   entryDirty;
  logic                   actWay;
  logic [tagBits-1:0]     actTag;

  // Address fields
  assign reqTag  = addr[AddrBits-1 -: tagBits];
  assign reqIdx  = addr[BlockOffBits +: idxBits];
  assign reqWord = addr[ByteOffBits +: WordOffBits];

  // A finished flush stays done until the CPU drops the request
  assign flushPending = flush & ~flushDone;
  assign cpuAccess    = (memRead | memWrite) & ~flushPending;

  // Tag compare on both ways
  assign hit0 = wayValid[0] & (wayTag0 == reqTag);
  assign hit1 = wayValid[1] & (wayTag1 == reqTag);
  assign hit  = hit0 | hit1;
  assign readWay = hit1;

  // Invalid way first, otherwise LRU
  assign victimWay   = ~wayValid[0] ? 1'b0 : (~wayValid[1] ? 1'b1 : lruWay);
  assign victimDirty = wayValid[victimWay] & wayDirty[victimWay];

  // Flush walks set and way, way in the low bit
  assign flushSet   = flushCount[idxBits:1];
  assign flushWay   = flushCount[0];
  assign flushLast  = &flushCount;
  assign entryDirty = wayValid[flushWay] & wayDirty[flushWay];

  assign lastBeat = (beat == WordOffBits'(BlockWords - 1));

  assign flushStep = ((state == Flush) & ~entryDirty) |
                     ((state == WriteBack) & flush & busReady & lastBeat);

  // Array addressing
  assign setIndex  = flush ? flushSet : reqIdx;
  assign wordIndex = ((state == WriteBack) | (state == MemRead)) ? beat : reqWord;
  assign writeTag  = reqTag;

  // Way that owns the current bus transfer
  assign actWay = flush ? flushWay : victimWay;
  assign actTag = actWay ? wayTag1 : wayTag0;

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  // Beat counter wraps back to zero after the fourth word
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      beat <= '0;
    end else if (((state == WriteBack) | (state == MemRead)) & busReady) begin
      beat <= beat + 1'b1;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      flushCount <= '0;
      flushDone  <= 1'b0;
    end else begin
      if (flushStep) begin
        flushCount <= flushCount + 1'b1;
      end
      if (~flush) begin
        flushDone <= 1'b0;
      end else if (flushStep & flushLast) begin
        flushDone <= 1'b1;
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Ready: begin
        if (flushPending) begin
          nextState = Flush;
        end else if (cpuAccess & ~hit) begin
          nextState = victimDirty ? WriteBack : MemRead;
        end
      end
      WriteBack: begin
        if (busReady & lastBeat) begin
          if (flush) begin
            nextState = flushLast ? Ready : Flush;
          end else begin
            nextState = MemRead;
          end
        end
      end
      MemRead: begin
        if (busReady & lastBeat) begin
          nextState = NextAccess;
        end
      end
      // Line is resident, the access completes as a hit in Ready
      NextAccess: nextState = Ready;
      Flush: begin
        if (entryDirty) begin
          nextState = WriteBack;
        end else if (flushLast) begin
          nextState = Ready;
        end
      end
      default: nextState = Ready;
    endcase
  end

  // Array update strobes
  always_comb begin
    wayWE      = 2'b00;
    fromBus    = 1'b0;
    setDirty   = 1'b0;
    clearDirty = 1'b0;
    setValid   = 1'b0;
    touchLru   = 1'b0;
    case (state)
      Ready: begin
        // wayWE also names the used way for the LRU update on loads
        if (cpuAccess & hit) begin
          wayWE    = hit1 ? 2'b10 : 2'b01;
          setDirty = memWrite;
          touchLru = 1'b1;
        end
      end
      MemRead: begin
        if (busReady) begin
          wayWE      = victimWay ? 2'b10 : 2'b01;
          fromBus    = 1'b1;
          setValid   = lastBeat;
          clearDirty = lastBeat;
        end
      end
      WriteBack: begin
        // A refill cleans the line itself, only flush needs this
        if (flush & busReady & lastBeat) begin
          wayWE      = flushWay ? 2'b10 : 2'b01;
          clearDirty = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign stall = (state != Ready) | flushPending | (cpuAccess & ~hit);

  assign busReq   = (state == WriteBack) | (state == MemRead);
  assign busWrite = (state == WriteBack);

  // Word address, that is the byte address shifted right by two
  assign busAddr = (state == WriteBack) ?
                   {{ByteOffBits{1'b0}}, actTag, setIndex, beat} :
                   {{ByteOffBits{1'b0}}, reqTag, reqIdx, beat};
  assign busWData = actWay ? wayWord1 : wayWord0;

endmodule

`default_nettype wire

//--- dcache/dcacheArray.sv
`default_nettype none

module dcacheArray
  import dcachePkg::*;
#(
  parameter int numLines = 16,
  localparam int idxBits = $clog2(numLines),
  localparam int tagBits = AddrBits - BlockOffBits - idxBits
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [idxBits-1:0]     setIndex,
  input  logic [WordOffBits-1:0] wordIndex,
  input  logic [1:0]             wayWE,
  input  logic                   fromBus,
  input  wordT                   busRData,
  input  wordT                   laneData,
  input  byteMaskT               byteMask,
  input  logic [tagBits-1:0]     writeTag,
  input  logic                   setDirty,
  input  logic                   clearDirty,
  input  logic                   setValid,
  input  logic                   touchLru,
  output logic [tagBits-1:0]     wayTag0,
  output logic [tagBits-1:0]     wayTag1,
  output logic [1:0]             wayValid,
  output logic [1:0]             wayDirty,
  output wordT                   wayWord0,
  output wordT                   wayWord1,
  output logic                   lruWay
);

  logic [tagBits-1:0] tagMem   [2][numLines];
  wordT               dataMem  [2][numLines][BlockWords];
  logic [1:0]         validMem [numLines];
  logic [1:0]         dirtyMem [numLines];
  logic [numLines-1:0] lruMem;

  // Status bits
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int s = 0; s < numLines; s++) begin
        validMem[s] <= 2'b00;
        dirtyMem[s] <= 2'b00;
      end
      lruMem <= '0;
    end else begin
      for (int w = 0; w < 2; w++) begin
        if (wayWE[w]) begin
          if (setValid) begin
            validMem[setIndex][w] <= 1'b1;
          end
          if (clearDirty) begin
            dirtyMem[setIndex][w] <= 1'b0;
          end else if (setDirty) begin
            dirtyMem[setIndex][w] <= 1'b1;
          end
        end
      end
      // Point at the way not just used
      if (touchLru) begin
        lruMem[setIndex] <= wayWE[0];
      end
    end
  end

  // Tags and data, data changes only on a bus fill or a store
  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWE[w]) begin
        if (setValid) begin
          tagMem[w][setIndex] <= writeTag;
        end
        if (fromBus) begin
          dataMem[w][setIndex][wordIndex] <= busRData;
        end else if (setDirty) begin
          for (int b = 0; b < $bits(byteMaskT); b++) begin
            if (byteMask[b]) begin
              dataMem[w][setIndex][wordIndex][8*b +: 8] <= laneData[8*b +: 8];
            end
          end
        end
      end
    end
  end

  assign wayTag0  = tagMem[0][setIndex];
  assign wayTag1  = tagMem[1][setIndex];
  assign wayValid = validMem[setIndex];
  assign wayDirty = dirtyMem[setIndex];
  assign wayWord0 = dataMem[0][setIndex][wordIndex];
  assign wayWord1 = dataMem[1][setIndex][wordIndex];
  assign lruWay   = lruMem[setIndex];

endmodule

`default_nettype wire

//--- hw/lsuAlign.sv
`default_nettype none

module lsuAlign
  import dcachePkg::*;
(
  input  accessSizeT accessSize,
  input  logic       signedLoad,
  input  logic [1:0] byteOffset,
  input  wordT       storeData,
  input  wordT       readWord,
  output byteMaskT   byteMask,
  output wordT       laneData,
  output wordT       loadData
);

  wordT shifted;

  // Store side, the mask picks which replicated lanes land
  always_comb begin
    case (accessSize)
      SizeByte: begin
        byteMask = byteMaskT'(4'b0001 << byteOffset);
        laneData = {4{storeData[7:0]}};
      end
      SizeHalf: begin
        byteMask = byteOffset[1] ? 4'b1100 : 4'b0011;
        laneData = {2{storeData[15:0]}};
      end
      default: begin
        byteMask = 4'b1111;
        laneData = storeData;
      end
    endcase
  end

  // Bring the addressed lanes down to bit 0
  assign shifted = readWord >> {byteOffset, 3'b000};

  always_comb begin
    case (accessSize)
      SizeByte: loadData = {{24{signedLoad & shifted[7]}}, shifted[7:0]};
      SizeHalf: loadData = {{16{signedLoad & shifted[15]}}, shifted[15:0]};
      default:  loadData = readWord;
    endcase
  end

endmodule

`default_nettype wire

//--- common/dcachePkg.sv
`default_nettype none

package dcachePkg;

  localparam int AddrBits = 32;

  // One data or address word
  typedef logic [AddrBits-1:0] wordT;

  // Byte lane enables within a word
  typedef logic [3:0] byteMaskT;

  // Block geometry
  localparam int BlockWords = 4;
  localparam int ByteOffBits = 2;
  localparam int WordOffBits = $clog2(BlockWords);
  localparam int BlockOffBits = WordOffBits + ByteOffBits;

  // Size of a CPU load or store
  typedef enum logic [1:0] {
    SizeByte,
    SizeHalf,
    SizeWord
  } accessSizeT;

  // Writeback controller states
  typedef enum logic [2:0] {
    Ready,
    WriteBack,
    MemRead,
    NextAccess,
    Flush
  } dcacheStateT;

endpackage

`default_nettype wire
